// File: source/core_pkg.sv
package core_pkg;

    parameter int XLEN = 64;
    parameter logic [11:0] CSR_MINSTRET = 12'hB02;

    // major opcodes of the supported subset.
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASSB} alu_op_e;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4, WB_CSR} wb_sel_e;

    typedef enum logic [1:0] {ST_RUN, ST_DRAIN, ST_ISSUE} ctrl_state_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [4:0]      rs1;   // zero when not read.
        logic [4:0]      rs2;
        logic [4:0]      rd;    // zero when not written.
        logic [XLEN-1:0] imm;
        alu_op_e         alu_op;
        logic            use_imm;
        wb_sel_e         wb_sel;
        logic            reg_write;
        logic            mem_read;
        logic            mem_write;
        logic            is_branch;
        logic            is_jal;
    } id_ex_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [4:0]      rd;
        logic [XLEN-1:0] alu_res;
        logic [XLEN-1:0] store_data;
        wb_sel_e         wb_sel;
        logic            reg_write;
        logic            mem_read;
        logic            mem_write;
    } ex_mw_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [4:0]      rd;
        logic            reg_write;
        logic [XLEN-1:0] data;
    } commit_t;

endpackage

// File: source/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          stall,
    input  logic                          flush,
    input  logic [63:0]                   redirect_pc,
    input  logic                          imem_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
    input  logic [31:0]                   imem_data,
    output logic [31:0]                   id_inst,
    output logic [63:0]                   id_pc,
    output logic                          id_valid
);
    logic [31:0] imem [IMEM_DEPTH];
    logic [63:0] pc;

    // loaded by the host while rst is high.
    always_ff @(posedge clk) begin
        if (imem_we)
            imem[imem_addr] <= imem_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= 64'd0;
            id_valid <= 1'b0;
        end else if (flush) begin
            pc       <= redirect_pc;  // taken branch or jal from EX.
            id_valid <= 1'b0;
        end else if (!stall) begin
            pc       <= pc + 64'd4;
            id_valid <= 1'b1;
        end
    end

    // IF/ID payload.
    always_ff @(posedge clk) begin
        if (!stall && !flush) begin
            id_inst <= imem[pc[2 +: $clog2(IMEM_DEPTH)]];
            id_pc   <= pc;
        end
    end

    // control must never freeze and redirect in the same edge.
    assert property (@(posedge clk) disable iff (rst) !(stall && flush));

endmodule

// File: source/decoder.sv
`timescale 1ns/1ns

module decoder (
    input  logic [31:0]               id_inst,
    input  logic [core_pkg::XLEN-1:0] id_pc,
    input  logic                      id_valid,
    output core_pkg::id_ex_t          id_dec,
    output logic [4:0]                rs1_addr,
    output logic [4:0]                rs2_addr,
    output logic                      csr_req
);
    import core_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] rd;
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_j;
    logic known;
    logic is_csr;

    assign funct3 = id_inst[14:12];
    assign funct7 = id_inst[31:25];
    assign rd = id_inst[11:7];
    assign rs1_addr = id_inst[19:15];
    assign rs2_addr = id_inst[24:20];

    assign imm_i = {{52{id_inst[31]}}, id_inst[31:20]};
    assign imm_s = {{52{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
    assign imm_b = {{51{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
                    id_inst[11:8], 1'b0};
    assign imm_j = {{43{id_inst[31]}}, id_inst[31], id_inst[19:12], id_inst[20],
                    id_inst[30:21], 1'b0};

    always_comb begin
        id_dec = '0;
        id_dec.pc = id_pc;
        id_dec.alu_op = ALU_ADD;
        id_dec.wb_sel = WB_ALU;
        known = 1'b1;
        is_csr = 1'b0;
        case (id_inst[6:0])
            OP: begin
                id_dec.rs1 = rs1_addr;
                id_dec.rs2 = rs2_addr;
                id_dec.rd = rd;
                id_dec.reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: id_dec.alu_op = ALU_ADD;
                    {7'h20, 3'b000}: id_dec.alu_op = ALU_SUB;
                    {7'h00, 3'b111}: id_dec.alu_op = ALU_AND;
                    {7'h00, 3'b110}: id_dec.alu_op = ALU_OR;
                    {7'h00, 3'b100}: id_dec.alu_op = ALU_XOR;
                    default: known = 1'b0;
                endcase
            end
            OP_IMM: begin  // addi only.
                id_dec.rs1 = rs1_addr;
                id_dec.rd = rd;
                id_dec.imm = imm_i;
                id_dec.use_imm = 1'b1;
                id_dec.reg_write = 1'b1;
                known = (funct3 == 3'b000);
            end
            LOAD: begin
                id_dec.rs1 = rs1_addr;
                id_dec.rd = rd;
                id_dec.imm = imm_i;
                id_dec.use_imm = 1'b1;
                id_dec.wb_sel = WB_MEM;
                id_dec.reg_write = 1'b1;
                id_dec.mem_read = 1'b1;
                known = (funct3 == 3'b011);
            end
            STORE: begin
                id_dec.rs1 = rs1_addr;
                id_dec.rs2 = rs2_addr;
                id_dec.imm = imm_s;
                id_dec.use_imm = 1'b1;
                id_dec.mem_write = 1'b1;
                known = (funct3 == 3'b011);
            end
            BRANCH: begin  // beq only.
                id_dec.rs1 = rs1_addr;
                id_dec.rs2 = rs2_addr;
                id_dec.imm = imm_b;
                id_dec.is_branch = 1'b1;
                known = (funct3 == 3'b000);
            end
            JAL: begin
                id_dec.rd = rd;
                id_dec.imm = imm_j;
                id_dec.wb_sel = WB_PC4;
                id_dec.reg_write = 1'b1;
                id_dec.is_jal = 1'b1;
            end
            SYSTEM: begin
                // csrrs rd, minstret, x0 is the only accepted form.
                is_csr = funct3 == 3'b010 && rs1_addr == 5'd0 &&
                         id_inst[31:20] == CSR_MINSTRET;
                known = is_csr;
                id_dec.rd = rd;
                id_dec.imm = imm_i;
                id_dec.use_imm = 1'b1;
                id_dec.alu_op = ALU_PASSB;
                id_dec.wb_sel = WB_CSR;
                id_dec.reg_write = 1'b1;
            end
            default: known = 1'b0;
        endcase
        id_dec.valid = id_valid && known;
        csr_req = id_valid && is_csr;
    end

endmodule

// File: source/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [4:0]                rs1_addr,
    input  logic [4:0]                rs2_addr,
    input  logic [4:0]                rd_addr,
    input  logic [core_pkg::XLEN-1:0] rd_data,
    input  logic                      rd_we,
    output logic [core_pkg::XLEN-1:0] rs1_data,
    output logic [core_pkg::XLEN-1:0] rs2_data
);
    logic [core_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (rd_we && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;  // x0 stays zero.
        end
    end

    // write-first, so ID sees the MW result of the same cycle.
    assign rs1_data = (rd_we && rd_addr != 5'd0 && rd_addr == rs1_addr) ? rd_data
                                                                         : regs[rs1_addr];
    assign rs2_data = (rd_we && rd_addr != 5'd0 && rd_addr == rs2_addr) ? rd_data
                                                                         : regs[rs2_addr];

endmodule

// File: source/exec_stage.sv
`timescale 1ns/1ns

module exec_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      bubble,
    input  logic                      flush,
    input  core_pkg::id_ex_t          id_dec,
    input  logic [core_pkg::XLEN-1:0] rs1_data,
    input  logic [core_pkg::XLEN-1:0] rs2_data,
    input  logic                      mw_fwd_we,
    input  logic [4:0]                mw_fwd_rd,
    input  logic [core_pkg::XLEN-1:0] mw_fwd_data,
    output core_pkg::ex_mw_t          ex_mw,
    output logic                      taken,
    output logic [core_pkg::XLEN-1:0] redirect_pc,
    output logic [4:0]                ex_load_rd,
    output logic                      ex_load_valid
);
    import core_pkg::*;

    id_ex_t ex_q;
    logic [XLEN-1:0] rs1_q, rs2_q;
    logic [XLEN-1:0] op_a, op_b, alu_b, alu_res;

    // ID/EX register.
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_q <= '0;
        end else begin
            ex_q <= id_dec;
            ex_q.valid <= id_dec.valid && !bubble && !flush;
        end
        rs1_q <= rs1_data;
        rs2_q <= rs2_data;
    end

    // forward the instruction now in MW.
    assign op_a = (mw_fwd_we && mw_fwd_rd != 5'd0 && mw_fwd_rd == ex_q.rs1) ? mw_fwd_data : rs1_q;
    assign op_b = (mw_fwd_we && mw_fwd_rd != 5'd0 && mw_fwd_rd == ex_q.rs2) ? mw_fwd_data : rs2_q;
    assign alu_b = ex_q.use_imm ? ex_q.imm : op_b;

    always_comb begin
        case (ex_q.alu_op)
            ALU_SUB: alu_res = op_a - alu_b;
            ALU_AND: alu_res = op_a & alu_b;
            ALU_OR: alu_res = op_a | alu_b;
            ALU_XOR: alu_res = op_a ^ alu_b;
            ALU_PASSB: alu_res = alu_b;
            default: alu_res = op_a + alu_b;
        endcase
    end

    assign taken = ex_q.valid && (ex_q.is_jal || (ex_q.is_branch && op_a == op_b));
    assign redirect_pc = ex_q.pc + ex_q.imm;
    assign ex_load_valid = ex_q.valid && ex_q.mem_read;
    assign ex_load_rd = ex_q.rd;

    // EX/MW register.
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mw <= '0;
        end else begin
            ex_mw.valid <= ex_q.valid;
            ex_mw.pc <= ex_q.pc;
            ex_mw.rd <= ex_q.rd;
            ex_mw.alu_res <= alu_res;
            ex_mw.store_data <= op_b;
            ex_mw.wb_sel <= ex_q.wb_sel;
            ex_mw.reg_write <= ex_q.reg_write;
            ex_mw.mem_read <= ex_q.mem_read;
            ex_mw.mem_write <= ex_q.mem_write;
        end
    end

    // the flush empties EX behind a redirect.
    assert property (@(posedge clk) disable iff (rst) taken |=> !ex_q.valid);

endmodule

// File: source/data_memory.sv
`timescale 1ns/1ns

module data_memory #(
    parameter int DMEM_DEPTH = 32
) (
    input  logic                      clk,
    input  logic [63:0]               addr,
    input  logic [core_pkg::XLEN-1:0] write_data,
    input  logic                      we,
    output logic [core_pkg::XLEN-1:0] read_data
);
    logic [core_pkg::XLEN-1:0] mem [DMEM_DEPTH];

    assign read_data = mem[addr[3 +: $clog2(DMEM_DEPTH)]];

    always_ff @(posedge clk) begin
        if (we)
            mem[addr[3 +: $clog2(DMEM_DEPTH)]] <= write_data;
    end

    // doubleword accesses only.
    assert property (@(posedge clk) addr[2:0] == 3'd0);

endmodule

// File: source/pipeline_control.sv
`timescale 1ns/1ns

module pipeline_control (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    id_valid,
    input  logic [4:0]              id_rs1,
    input  logic [4:0]              id_rs2,
    input  logic                    csr_req,
    input  logic                    ex_load_valid,
    input  logic [4:0]              ex_load_rd,
    input  logic                    ex_busy,
    input  logic                    mw_busy,
    input  logic                    taken,
    output logic                    stall,
    output logic                    bubble,
    output logic                    flush,
    output core_pkg::ctrl_state_e   state
);
    import core_pkg::*;

    ctrl_state_e state_next;
    logic load_use;
    logic drain;

    assign load_use = id_valid && ex_load_valid && ex_load_rd != 5'd0 &&
                      (ex_load_rd == id_rs1 || ex_load_rd == id_rs2);
    // hold the CSR from the first cycle it shows up in ID.
    assign drain = state == ST_DRAIN || (state == ST_RUN && csr_req);

    assign flush = taken;
    assign stall = !taken && (load_use || drain);
    assign bubble = stall;

    always_comb begin
        state_next = state;
        if (taken) begin
            state_next = ST_RUN;  // the waiting CSR was discarded.
        end else begin
            case (state)
                ST_RUN: if (csr_req) state_next = ST_DRAIN;
                ST_DRAIN: if (!ex_busy && !mw_busy) state_next = ST_ISSUE;
                default: state_next = ST_RUN;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            state <= ST_RUN;
        else
            state <= state_next;
    end

    // the CSR issues into an empty pipeline.
    assert property (@(posedge clk) disable iff (rst)
        state == ST_ISSUE |-> !ex_busy && !mw_busy);

endmodule

// File: source/retire_counter.sv
`timescale 1ns/1ns

module retire_counter (
    input  logic        clk,
    input  logic        rst,
    input  logic        commit_valid,
    output logic [63:0] minstret
);
    always_ff @(posedge clk) begin
        if (rst)
            minstret <= 64'd0;
        else if (commit_valid)
            minstret <= minstret + 64'd1;
    end

endmodule

// File: source/core_top.sv
`timescale 1ns/1ns

module core_top #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          imem_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
    input  logic [31:0]                   imem_data,
    output core_pkg::commit_t             commit
);
    import core_pkg::*;

    logic [31:0] id_inst;
    logic [XLEN-1:0] id_pc;
    logic id_valid;
    id_ex_t id_dec;
    logic [4:0] rs1_addr, rs2_addr;
    logic [XLEN-1:0] rs1_data, rs2_data;
    logic csr_req;
    logic stall, bubble, flush;
    ctrl_state_e ctrl_state;
    logic taken;
    logic [XLEN-1:0] redirect_pc;
    logic [4:0] ex_load_rd;
    logic ex_load_valid;
    logic ex_busy;
    ex_mw_t mw;
    logic mw_we;
    logic [XLEN-1:0] dmem_addr, dmem_rdata, wb_data, minstret;

    fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
        .clk, .rst, .stall, .flush, .redirect_pc,
        .imem_we, .imem_addr, .imem_data,
        .id_inst, .id_pc, .id_valid
    );

    decoder u_decoder (.id_inst, .id_pc, .id_valid, .id_dec, .rs1_addr, .rs2_addr, .csr_req);

    reg_file u_reg_file (
        .clk, .rst, .rs1_addr, .rs2_addr,
        .rd_addr(mw.rd), .rd_data(wb_data), .rd_we(mw_we),
        .rs1_data, .rs2_data
    );

    exec_stage u_exec (
        .clk, .rst, .bubble, .flush, .id_dec, .rs1_data, .rs2_data,
        .mw_fwd_we(mw_we), .mw_fwd_rd(mw.rd), .mw_fwd_data(wb_data),
        .ex_mw(mw), .taken, .redirect_pc, .ex_load_rd, .ex_load_valid
    );

    pipeline_control u_ctrl (
        .clk, .rst, .id_valid, .id_rs1(id_dec.rs1), .id_rs2(id_dec.rs2), .csr_req,
        .ex_load_valid, .ex_load_rd, .ex_busy, .mw_busy(mw.valid), .taken,
        .stall, .bubble, .flush, .state(ctrl_state)
    );

    // ID/EX occupancy, seen by the CSR drain.
    always_ff @(posedge clk) begin
        if (rst)
            ex_busy <= 1'b0;
        else
            ex_busy <= id_dec.valid && !bubble && !flush;
    end

    // memory / writeback stage.
    assign dmem_addr = (mw.valid && (mw.mem_read || mw.mem_write)) ? mw.alu_res : '0;

    data_memory #(.DMEM_DEPTH(DMEM_DEPTH)) u_dmem (
        .clk, .addr(dmem_addr), .write_data(mw.store_data),
        .we(mw.valid && mw.mem_write), .read_data(dmem_rdata)
    );

    always_comb begin
        case (mw.wb_sel)
            WB_MEM: wb_data = dmem_rdata;
            WB_PC4: wb_data = mw.pc + 64'd4;
            WB_CSR: wb_data = minstret;  // drained, so exact.
            default: wb_data = mw.alu_res;
        endcase
    end

    assign mw_we = mw.valid && mw.reg_write;
    assign commit = '{valid: mw.valid, pc: mw.pc, rd: mw.rd,
                      reg_write: mw.reg_write, data: wb_data};

    retire_counter u_minstret (.clk, .rst, .commit_valid(mw.valid), .minstret);

    // a CSR leaves ID only through the single issue cycle.
    assert property (@(posedge clk) disable iff (rst)
        (csr_req && !stall && !flush) |-> ctrl_state == ST_ISSUE);

endmodule

// File: include/isa_model.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

localparam int PROG_LEN = 40;

logic [31:0] prog [PROG_LEN];
logic [63:0] m_regs [32];
logic [63:0] m_mem [DMEM_DEPTH];
logic [63:0] m_pc;
longint unsigned m_retired;
int unsigned lcg_state;

function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 8;
endfunction

// random subset program, and the model state cleared to match reset.
task automatic gen_program();
    logic [4:0] rd, rs1, rs2;
    logic [11:0] imm, off;
    logic [12:0] b_off;
    logic [20:0] j_off;
    int unsigned span;
    lcg_state = 59;
    m_pc = '0;
    m_retired = 0;
    foreach (m_regs[i]) m_regs[i] = '0;
    foreach (m_mem[i]) m_mem[i] = '0;
    for (int i = 0; i < PROG_LEN - 1; i++) begin
        rd = 5'(lcg_next() % 8);
        rs1 = 5'(lcg_next() % 8);
        rs2 = 5'(lcg_next() % 8);
        imm = 12'(lcg_next() % 64) - 12'd32;
        off = 12'((lcg_next() % DMEM_DEPTH) * 8);
        span = 1 + lcg_next() % 4;  // forward only, never past the last word.
        if (i + span > PROG_LEN - 1)
            span = PROG_LEN - 1 - i;
        b_off = 13'(span * 4);
        j_off = 21'(span * 4);
        case (lcg_next() % 12)
            0: prog[i] = {7'h00, rs2, rs1, 3'b000, rd, core_pkg::OP};
            1: prog[i] = {7'h20, rs2, rs1, 3'b000, rd, core_pkg::OP};
            2: prog[i] = {7'h00, rs2, rs1, 3'b111, rd, core_pkg::OP};
            3: prog[i] = {7'h00, rs2, rs1, 3'b110, rd, core_pkg::OP};
            4: prog[i] = {7'h00, rs2, rs1, 3'b100, rd, core_pkg::OP};
            5, 6: prog[i] = {imm, rs1, 3'b000, rd, core_pkg::OP_IMM};
            7: prog[i] = {off, 5'd0, 3'b011, rd, core_pkg::LOAD};
            8: prog[i] = {off[11:5], rs2, 5'd0, 3'b011, off[4:0], core_pkg::STORE};
            9: prog[i] = {b_off[12], b_off[10:5], rs2, rs1, 3'b000, b_off[4:1], b_off[11],
                          core_pkg::BRANCH};
            10: prog[i] = {j_off[20], j_off[10:1], j_off[11], j_off[19:12], rd, core_pkg::JAL};
            default: prog[i] = {core_pkg::CSR_MINSTRET, 5'd0, 3'b010, rd, core_pkg::SYSTEM};
        endcase
    end
    prog[PROG_LEN-1] = {25'd0, core_pkg::JAL};  // jal x0, 0.
endtask

// one retired instruction of the reference model.
task automatic model_step(output logic [63:0] exp_pc, output logic [4:0] exp_rd,
                          output logic exp_we, output logic [63:0] exp_data);
    logic [31:0] inst;
    logic [63:0] a, b, imm_i, nxt;
    inst = prog[int'(m_pc >> 2)];
    a = m_regs[inst[19:15]];
    b = m_regs[inst[24:20]];
    imm_i = {{52{inst[31]}}, inst[31:20]};
    nxt = m_pc + 64'd4;
    exp_pc = m_pc;
    exp_rd = inst[11:7];
    exp_we = 1'b1;
    exp_data = '0;
    case (inst[6:0])
        core_pkg::OP: begin
            case ({inst[30], inst[14:12]})
                4'b1000: exp_data = a - b;
                4'b0111: exp_data = a & b;
                4'b0110: exp_data = a | b;
                4'b0100: exp_data = a ^ b;
                default: exp_data = a + b;
            endcase
        end
        core_pkg::OP_IMM: exp_data = a + imm_i;
        core_pkg::LOAD: exp_data = m_mem[int'((a + imm_i) >> 3)];
        core_pkg::STORE: begin
            m_mem[int'((a + {{52{inst[31]}}, inst[31:25], inst[11:7]}) >> 3)] = b;
            exp_we = 1'b0;
            exp_rd = 5'd0;
        end
        core_pkg::BRANCH: begin
            if (a == b)
                nxt = m_pc + {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            exp_we = 1'b0;
            exp_rd = 5'd0;
        end
        core_pkg::JAL: begin
            exp_data = m_pc + 64'd4;
            nxt = m_pc + {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        default: exp_data = m_retired;  // csrrs minstret.
    endcase
    if (exp_we && exp_rd != 5'd0)
        m_regs[exp_rd] = exp_data;
    m_pc = nxt;
    m_retired++;
endtask

`endif

// File: test/tb_core.sv
`timescale 1ns/1ns

module tb_core;
    import core_pkg::*;

    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 32;
    localparam int IMEM_AW = $clog2(IMEM_DEPTH);

    `include "isa_model.svh"

    localparam int CYCLE_LIMIT = PROG_LEN * 8 + 50;
    localparam logic [63:0] LAST_PC = 64'((PROG_LEN - 1) * 4);

    logic clk;
    logic rst;
    logic imem_we;
    logic [IMEM_AW-1:0] imem_addr;
    logic [31:0] imem_data;
    commit_t commit;

    // model's view of the instruction now on the commit port.
    logic [63:0] exp_pc;
    logic [4:0] exp_rd;
    logic exp_we;
    logic [63:0] exp_data;

    int pc_errors;
    int rd_errors;
    int we_errors;
    int data_errors;
    int reset_errors;
    int cycles;
    int last_seen;
    logic timed_out;

    core_top #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) dut (
        .clk, .rst, .imem_we, .imem_addr, .imem_data, .commit
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    assert property (@(posedge clk) rst && $past(rst) |-> !commit.valid)
        else begin
            reset_errors++;
            $display("ERROR %0t commit.valid expected 0 seen %0b", $time,
                     $sampled(commit.valid));
        end

    assert property (@(posedge clk) disable iff (rst) commit.valid |-> commit.pc == exp_pc)
        else begin
            pc_errors++;
            $display("ERROR %0t commit.pc expected %h seen %h", $time, exp_pc,
                     $sampled(commit.pc));
        end

    assert property (@(posedge clk) disable iff (rst) commit.valid |-> commit.rd == exp_rd)
        else begin
            rd_errors++;
            $display("ERROR %0t commit.rd expected %0d seen %0d", $time, exp_rd,
                     $sampled(commit.rd));
        end

    assert property (@(posedge clk) disable iff (rst)
        commit.valid |-> commit.reg_write == exp_we)
        else begin
            we_errors++;
            $display("ERROR %0t commit.reg_write expected %0b seen %0b", $time, exp_we,
                     $sampled(commit.reg_write));
        end

    // stores and branches write nothing, so their data is not compared.
    assert property (@(posedge clk) disable iff (rst)
        commit.valid && exp_we |-> commit.data == exp_data)
        else begin
            data_errors++;
            $display("ERROR %0t commit.data expected %h seen %h", $time, exp_data,
                     $sampled(commit.data));
        end

    initial begin
        rst = 1'b1;
        imem_we = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        exp_pc = '0;
        exp_rd = '0;
        exp_we = 1'b0;
        exp_data = '0;
        pc_errors = 0;
        rd_errors = 0;
        we_errors = 0;
        data_errors = 0;
        reset_errors = 0;
        cycles = 0;
        last_seen = 0;
        timed_out = 1'b0;
        gen_program();

        // reset holds the core through the load.
        for (int i = 0; i < PROG_LEN; i++) begin
            @(negedge clk);
            imem_we = 1'b1;
            imem_addr = i[IMEM_AW-1:0];
            imem_data = prog[i];
        end
        @(negedge clk);
        imem_we = 1'b0;
        repeat (3) @(negedge clk);  // three quiet reset cycles.
        rst = 1'b0;

        // the final jal spins on itself, two laps end the run.
        while (last_seen < 2 && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (commit.valid) begin
                model_step(exp_pc, exp_rd, exp_we, exp_data);
                if (exp_pc == LAST_PC)
                    last_seen++;
            end
            if (cycles >= CYCLE_LIMIT)
                timed_out = 1'b1;
        end
        @(posedge clk);
        #1;

        if (timed_out)
            $display("core stopped retiring, %0d commits in %0d cycles", m_retired, cycles);
        $display("errors: pc %0d, rd %0d, reg_write %0d, data %0d, reset %0d",
                 pc_errors, rd_errors, we_errors, data_errors, reset_errors);
        if (!timed_out && pc_errors + rd_errors + we_errors + data_errors + reset_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// File: project.f
+incdir+include
source/core_pkg.sv
source/fetch_stage.sv
source/decoder.sv
source/reg_file.sv
source/exec_stage.sv
source/data_memory.sv
source/pipeline_control.sv
source/retire_counter.sv
source/core_top.sv
test/tb_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_core \
    -f project.f -o sim_tb_core

if ! ./obj_dir/sim_tb_core > sim.log 2>&1; then
    cat sim.log
    echo "simulator exited with an error"
    exit 1
fi
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0
